// File: Makefile
SRCS := $(shell cat all.f)

obj_dir/Vi2s_tx_tb: all.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module i2s_tx_tb -f all.f

run: obj_dir/Vi2s_tx_tb
	./obj_dir/Vi2s_tx_tb > sim.log 2>&1; cat sim.log
	grep -q "^No errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: all.f
source/i2s_pkg.sv
source/audio_fifo.sv
source/i2s_master.sv
source/i2s_tx_top.sv
verif/tb_clock.sv
verif/i2s_rx_model.sv
verif/i2s_tx_tb.sv

// File: source/audio_fifo.sv
`timescale 1ns/1ps

module audio_fifo (
   input  logic            clk_soc,
   input  logic            ac_mclk,
   input  logic            reset,

   // Write side, clk_soc
   input  i2s_pkg::frame_t wr_data,
   input  logic            wr_strobe,
   output logic            full,

   // Read side, ac_mclk
   input  logic            rd_strobe,
   output i2s_pkg::frame_t rd_data,
   output logic            empty
);

   // Frame storage, no reset
   i2s_pkg::frame_t mem [i2s_pkg::FIFO_DEPTH];

   // Write domain state
   i2s_pkg::fifo_ptr_t wr_bin;        // Binary write pointer
   i2s_pkg::fifo_ptr_t wr_bin_next;
   i2s_pkg::fifo_ptr_t wr_gray;       // Registered Gray copy, crosses to ac_mclk
   i2s_pkg::fifo_ptr_t rd_gray_s1;    // Read pointer sync, first flop
   i2s_pkg::fifo_ptr_t rd_gray_s2;    // Read pointer sync, second flop
   logic               wr_accept;

   // Read domain state
   i2s_pkg::fifo_ptr_t rd_bin;
   i2s_pkg::fifo_ptr_t rd_bin_next;
   i2s_pkg::fifo_ptr_t rd_gray;       // Crosses to clk_soc
   i2s_pkg::fifo_ptr_t wr_gray_s1;
   i2s_pkg::fifo_ptr_t wr_gray_s2;
   logic               rd_accept;

   // Write side

   assign wr_accept = wr_strobe && !full;   // Writes while full are dropped
   assign wr_bin_next = wr_bin + i2s_pkg::fifo_ptr_t'(wr_accept);

   always_ff @(posedge clk_soc) begin
      if (reset) begin
         wr_bin <= '0;
         wr_gray <= '0;
      end else begin
         wr_bin <= wr_bin_next;
         wr_gray <= i2s_pkg::to_gray(wr_bin_next);   // Only one bit changes per step
      end
   end

   always_ff @(posedge clk_soc) begin
      if (wr_accept) begin
         mem[wr_bin[i2s_pkg::FIFO_AW-1:0]] <= wr_data;
      end
   end

   // Bring read pointer into clk_soc
   always_ff @(posedge clk_soc) begin
      if (reset) begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   // Full when write is one lap ahead
   // In Gray code the top two bits differ and the rest match
   assign full = (wr_gray == {~rd_gray_s2[i2s_pkg::FIFO_AW:i2s_pkg::FIFO_AW-1],
                              rd_gray_s2[i2s_pkg::FIFO_AW-2:0]});

   // Read side

   assign rd_accept = rd_strobe && !empty;   // Guard against a stray pop
   assign rd_bin_next = rd_bin + i2s_pkg::fifo_ptr_t'(rd_accept);

   always_ff @(posedge ac_mclk) begin
      if (reset) begin
         rd_bin <= '0;
         rd_gray <= '0;
      end else begin
         rd_bin <= rd_bin_next;
         rd_gray <= i2s_pkg::to_gray(rd_bin_next);
      end
   end

   // Bring write pointer into ac_mclk
   always_ff @(posedge ac_mclk) begin
      if (reset) begin
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   // Show-ahead: oldest entry always visible
   assign rd_data = mem[rd_bin[i2s_pkg::FIFO_AW-1:0]];

   // Empty while pointers match, lags new writes by the sync delay
   assign empty = (rd_gray == wr_gray_s2);

endmodule

// File: source/i2s_master.sv
`timescale 1ns/1ps

module i2s_master (
   input  logic                     ac_mclk,
   input  logic                     reset,

   // FIFO read port
   input  i2s_pkg::frame_t          rd_data,
   input  logic                     empty,
   output logic                     rd_strobe,

   // Serial lines toward the codec
   output logic                     bclk,
   output logic                     lrclk,
   output logic                     sdata,

   output i2s_pkg::underrun_count_t underrun_count
);

   // Startup FSM
   typedef enum logic [1:0] {
      wait_data,   // Idle until the first frame arrives
      prime,       // Let the first pop settle
      run          // Free-running serializer
   } tx_state_t;

   tx_state_t           state;
   i2s_pkg::step_div_t  div_cnt;      // ac_mclk cycles within a step
   i2s_pkg::bit_cnt_t   bit_cnt;      // Step within half-frame
   i2s_pkg::sample_t    shift_reg;    // MSB drives sdata
   i2s_pkg::frame_t     hold_frame;   // Next frame to send
   i2s_pkg::sample_t    right_buf;    // Right sample of frame in flight
   logic                hold_silent;  // hold_frame is stale, send zeros

   logic run_step;      // One counter step this cycle
   logic slot_wrap;     // Counter wraps from the last step
   logic left_start;    // lrclk about to fall
   logic right_start;   // lrclk about to rise
   logic first_pop;
   logic refill;
   logic take_frame;

   assign run_step = (state == run) &&
                     (div_cnt == i2s_pkg::step_div_t'(i2s_pkg::MCLK_PER_STEP - 1));
   assign slot_wrap = run_step && (bit_cnt == i2s_pkg::bit_cnt_t'(i2s_pkg::SLOT_STEPS - 1));
   assign left_start = slot_wrap && lrclk;
   assign right_start = slot_wrap && !lrclk;

   // Pops: first frame at startup, then one per left-slot boundary
   assign first_pop = (state == wait_data) && !empty;
   assign refill = left_start && !empty;
   assign take_frame = first_pop || refill;

   assign sdata = shift_reg[i2s_pkg::SAMPLE_BITS-1];

   // Control path
   always_ff @(posedge ac_mclk) begin
      if (reset) begin
         state <= wait_data;
         div_cnt <= '0;
         bit_cnt <= '1;         // Start on the last step so the first step wraps
         bclk <= 1'b0;
         lrclk <= 1'b1;         // First edge is a falling one, left slot
         shift_reg <= '0;
         hold_silent <= 1'b1;
         rd_strobe <= 1'b0;
         underrun_count <= '0;
      end else begin
         rd_strobe <= take_frame;   // Single-cycle pulse

         case (state)
            wait_data: begin
               if (first_pop) begin
                  state <= prime;
               end
            end
            prime: begin
               state <= run;
            end
            default: begin
               state <= run;
            end
         endcase

         if (state == run) begin
            if (run_step) begin
               div_cnt <= '0;
            end else begin
               div_cnt <= div_cnt + 1'b1;
            end
         end

         if (run_step) begin
            bit_cnt <= bit_cnt + 1'b1;   // Wraps 63 to 0 by width
            if (bit_cnt < i2s_pkg::bit_cnt_t'(i2s_pkg::BCLK_STEPS)) begin
               bclk <= ~bclk;            // 24 pulses, then parked low
            end
         end

         if (slot_wrap) begin
            lrclk <= ~lrclk;
         end

         // Load at slot start, shift on each falling bclk
         if (left_start) begin
            shift_reg <= hold_silent ? '0 : hold_frame.left;
         end else if (right_start) begin
            shift_reg <= right_buf;
         end else if (run_step && bclk) begin
            shift_reg <= {shift_reg[i2s_pkg::SAMPLE_BITS-2:0], 1'b0};   // Zero fill after LSB
         end

         // Silence tracking
         if (first_pop) begin
            hold_silent <= 1'b0;
         end else if (left_start) begin
            hold_silent <= empty;   // Nothing to refill with
         end

         if (left_start && empty) begin
            underrun_count <= underrun_count + 1'b1;
         end
      end
   end

   // Payload registers
   always_ff @(posedge ac_mclk) begin
      if (take_frame) begin
         hold_frame <= rd_data;   // Show-ahead data is valid with the pop
      end
      if (left_start) begin
         right_buf <= hold_silent ? '0 : hold_frame.right;   // Kept until lrclk rises
      end
   end

endmodule

// File: source/i2s_pkg.sv
package i2s_pkg;

   // Audio format
   localparam int SAMPLE_BITS = 24;           // Data bits per channel slot
   localparam int SLOT_STEPS = 64;            // Bit-counter steps per half-frame
   localparam int MCLK_PER_STEP = 2;          // ac_mclk cycles per counter step
   localparam int BCLK_STEPS = 2 * SAMPLE_BITS; // Steps with bclk running

   // Counter widths for the serializer
   localparam int BIT_CNT_W = $clog2(SLOT_STEPS);
   localparam int STEP_DIV_W = (MCLK_PER_STEP > 1) ? $clog2(MCLK_PER_STEP) : 1;

   // FIFO sizing
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW = 4;                // log2 of FIFO_DEPTH

   typedef logic [SAMPLE_BITS-1:0] sample_t;
   typedef logic [15:0] underrun_count_t;     // Wraps at 16 bits
   typedef logic [FIFO_AW:0] fifo_ptr_t;      // Extra MSB for wrap detection
   typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
   typedef logic [STEP_DIV_W-1:0] step_div_t;

   // One stereo frame
   typedef struct packed {
      sample_t left;    // Upper half
      sample_t right;   // Lower half
   } frame_t;

   // Binary to Gray for pointer crossing
   function automatic fifo_ptr_t to_gray(fifo_ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

endpackage

// File: source/i2s_tx_top.sv
`timescale 1ns/1ps

module i2s_tx_top (
   input  logic                     clk_soc,
   input  logic                     ac_mclk,
   input  logic                     reset,

   // System write port
   input  i2s_pkg::frame_t          frame_in,
   input  logic                     write_frame,
   output logic                     full,

   // Codec lines
   output logic                     bclk,
   output logic                     lrclk,
   output logic                     sdata,

   output i2s_pkg::underrun_count_t underrun_count
);

   // FIFO to serializer, ac_mclk domain
   i2s_pkg::frame_t rd_data;
   logic            empty;
   logic            rd_strobe;

   // Crosses frames from clk_soc to ac_mclk
   audio_fifo audio_fifo_i (
      .clk_soc   (clk_soc),
      .ac_mclk   (ac_mclk),
      .reset     (reset),
      .wr_data   (frame_in),
      .wr_strobe (write_frame),
      .full      (full),
      .rd_strobe (rd_strobe),
      .rd_data   (rd_data),
      .empty     (empty)
   );

   // Serializer runs off ac_mclk only
   i2s_master i2s_master_i (
      .ac_mclk        (ac_mclk),
      .reset          (reset),
      .rd_data        (rd_data),
      .empty          (empty),
      .rd_strobe      (rd_strobe),
      .bclk           (bclk),
      .lrclk          (lrclk),
      .sdata          (sdata),
      .underrun_count (underrun_count)
   );

endmodule

// File: verif/i2s_rx_model.sv
`timescale 1ns/1ps

module i2s_rx_model (
   input  logic            ac_mclk,
   input  logic            reset,

   // Serial lines from the DUT
   input  logic            bclk,
   input  logic            lrclk,
   input  logic            sdata,

   output i2s_pkg::frame_t frame,
   output logic            frame_valid   // One ac_mclk cycle per captured frame
);

   logic             bclk_q;
   logic             lrclk_q;
   logic [4:0]       bit_cnt;   // Bits taken in this slot
   i2s_pkg::sample_t shift;
   i2s_pkg::sample_t left_q;    // Left sample waiting for its right half
   i2s_pkg::sample_t word;

   assign word = {shift[i2s_pkg::SAMPLE_BITS-2:0], sdata};   // Shift plus current bit

   // Oversampled by ac_mclk, bclk edges found from the delayed copy
   always_ff @(posedge ac_mclk) begin
      if (reset) begin
         bclk_q <= 1'b0;
         lrclk_q <= 1'b1;
         bit_cnt <= '0;
         shift <= '0;
         left_q <= '0;
         frame <= '0;
         frame_valid <= 1'b0;
      end else begin
         bclk_q <= bclk;
         lrclk_q <= lrclk;
         frame_valid <= 1'b0;
         if (lrclk != lrclk_q) begin
            bit_cnt <= '0;   // Word clock edge starts a slot
         end else if (bclk && !bclk_q && bit_cnt < 5'(i2s_pkg::SAMPLE_BITS)) begin
            shift <= word;
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == 5'(i2s_pkg::SAMPLE_BITS - 1)) begin
               if (lrclk) begin
                  frame <= {left_q, word};   // Right slot done
                  frame_valid <= 1'b1;
               end else begin
                  left_q <= word;
               end
            end
         end
      end
   end

endmodule

// File: verif/i2s_tx_tb.sv
`timescale 1ns/1ps

module i2s_tx_tb;

   localparam int STREAM_FRAMES = 40;
   localparam int WRITE_GAP = 40;        // clk_soc cycles between stream writes
   localparam int SILENT_WAIT = 3;       // Silent frames seen before new data
   localparam int FULL_WAIT = 1000;      // clk_soc cycles, about three frames
   localparam int FRAME_MCLKS = 2 * i2s_pkg::SLOT_STEPS * i2s_pkg::MCLK_PER_STEP;
   // Data frames of all tests plus silence around them
   localparam int TOTAL_FRAMES = 1 + STREAM_FRAMES + i2s_pkg::FIFO_DEPTH + 8 + SILENT_WAIT + 20;
   localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * FRAME_MCLKS + 1000;

   logic                     ac_mclk;
   logic                     clk_soc;
   logic                     reset;
   i2s_pkg::frame_t          frame_in;
   logic                     write_frame;
   logic                     full;
   logic                     bclk;
   logic                     lrclk;
   logic                     sdata;
   i2s_pkg::underrun_count_t underrun_count;
   i2s_pkg::frame_t          rx_frame;
   logic                     rx_valid;

   i2s_pkg::frame_t          exp_q[$];   // Accepted writes, oldest first
   i2s_pkg::frame_t          cap_q[$];   // Frames from the receiver model
   i2s_pkg::underrun_count_t cnt_q[$];   // underrun_count seen with each capture
   logic [31:0]              rng_state;
   int                       cycles = 0;

   tb_clock tb_clock_i (.ac_mclk(ac_mclk), .clk_soc(clk_soc), .reset(reset));

   i2s_tx_top i2s_tx_top_i (
      .clk_soc        (clk_soc),
      .ac_mclk        (ac_mclk),
      .reset          (reset),
      .frame_in       (frame_in),
      .write_frame    (write_frame),
      .full           (full),
      .bclk           (bclk),
      .lrclk          (lrclk),
      .sdata          (sdata),
      .underrun_count (underrun_count)
   );

   i2s_rx_model i2s_rx_model_i (
      .ac_mclk     (ac_mclk),
      .reset       (reset),
      .bclk        (bclk),
      .lrclk       (lrclk),
      .sdata       (sdata),
      .frame       (rx_frame),
      .frame_valid (rx_valid)
   );

   // Collect captures mid-cycle, away from the clock edge
   always @(negedge ac_mclk) begin
      if (rx_valid) begin
         cap_q.push_back(rx_frame);
         cnt_q.push_back(underrun_count);
      end
   end

   always @(posedge ac_mclk) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("Timeout: run not finished after %0d ac_mclk cycles", TIMEOUT_CYCLES);
         stop_run();
      end
   end

   task automatic stop_run();
      $display("Errors found");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic value_error(input string msg);
      $display("** Error at time %0t: %s", $time, msg);
      stop_run();
   endtask

   task automatic check_frame(input string what, input i2s_pkg::frame_t got,
                              input i2s_pkg::frame_t want);
      if (got !== want) value_error($sformatf("%s: got %h, expected %h", what, got, want));
   endtask

   task automatic check_count(input string what, input i2s_pkg::underrun_count_t got,
                              input i2s_pkg::underrun_count_t want);
      if (got !== want) value_error($sformatf("%s: got %0d, expected %0d", what, got, want));
   endtask

   task automatic check_level(input string what, input logic got, input logic want);
      if (got !== want) value_error($sformatf("%s: got %b, expected %b", what, got, want));
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic random_frame(output i2s_pkg::frame_t f);
      rng_state = xorshift(rng_state);
      f.left = rng_state[23:0];
      rng_state = xorshift(rng_state);
      f.right = rng_state[23:0];
      if (f == '0) f.right = 24'h1;   // All zeros is reserved for silence
   endtask

   // Drive point, just after the clk_soc edge
   task automatic soc_tick();
      @(posedge clk_soc);
      #1;
   endtask

   task automatic write_one(input i2s_pkg::frame_t f);
      soc_tick();
      while (full) soc_tick();   // full is steady until the next edge
      frame_in = f;
      write_frame = 1'b1;
      exp_q.push_back(f);
      soc_tick();
      write_frame = 1'b0;
   endtask

   task automatic next_capture(output i2s_pkg::frame_t f, output i2s_pkg::underrun_count_t c);
      while (cap_q.size() == 0) @(negedge ac_mclk);
      f = cap_q.pop_front();
      c = cnt_q.pop_front();
   endtask

   // First non-silent capture and the number of zero frames before it
   task automatic skip_silence(output i2s_pkg::frame_t f, output i2s_pkg::underrun_count_t c,
                               output int silent);
      silent = 0;
      next_capture(f, c);
      while (f == '0) begin
         silent++;
         next_capture(f, c);
      end
   endtask

   // n frames back to back in write order, count frozen if steady
   task automatic receive_frames(input int n, input bit steady);
      i2s_pkg::frame_t          got;
      i2s_pkg::frame_t          want;
      i2s_pkg::underrun_count_t cnt;
      i2s_pkg::underrun_count_t base;
      int                       silent;
      skip_silence(got, cnt, silent);
      base = cnt;
      for (int i = 0; i < n; i++) begin
         if (i > 0) next_capture(got, cnt);   // A zero here is silence inside the stream
         if (exp_q.size() == 0) begin
            $display("Receiver captured a frame that was never written");
            stop_run();
         end
         want = exp_q.pop_front();
         check_frame($sformatf("frame %0d", i), got, want);
         // Last frame finds the FIFO empty behind it
         if (steady && i < n - 1) check_count($sformatf("underrun_count at frame %0d", i), cnt, base);
      end
   endtask

   task automatic test_reset_state();
      @(negedge reset);
      @(negedge ac_mclk);
      check_level("bclk after reset", bclk, 1'b0);
      check_level("lrclk after reset", lrclk, 1'b1);
      check_level("sdata after reset", sdata, 1'b0);
      check_level("full after reset", full, 1'b0);
      check_count("underrun_count after reset", underrun_count, '0);
      repeat (300) begin
         @(negedge ac_mclk);
         check_level("bclk with FIFO empty", bclk, 1'b0);   // Serializer must not start
      end
   endtask

   task automatic test_single_frame();
      i2s_pkg::frame_t f;
      random_frame(f);
      write_one(f);
      receive_frames(1, 1'b0);
   endtask

   // Writer paced by full once the FIFO fills
   task automatic test_stream();
      i2s_pkg::frame_t f;
      fork
         begin
            for (int i = 0; i < STREAM_FRAMES; i++) begin
               random_frame(f);
               write_one(f);
               repeat (WRITE_GAP) soc_tick();
            end
         end
         receive_frames(STREAM_FRAMES, 1'b1);
      join
   endtask

   task automatic test_full();
      i2s_pkg::frame_t f;
      int              dropped;
      int              waited;
      int              n;
      dropped = 0;
      while (dropped < 4) begin   // Keep writing a few cycles into full
         random_frame(f);
         soc_tick();
         if (full) dropped++;
         else exp_q.push_back(f);
         frame_in = f;
         write_frame = 1'b1;
      end
      soc_tick();
      write_frame = 1'b0;
      waited = 0;
      while (full) begin
         soc_tick();
         waited++;
         if (waited > FULL_WAIT) begin
            $display("full stayed high while the serializer was draining the FIFO");
            stop_run();
         end
      end
      n = exp_q.size();
      receive_frames(n, 1'b1);
   endtask

   task automatic test_underrun();
      i2s_pkg::frame_t          f;
      i2s_pkg::frame_t          got;
      i2s_pkg::frame_t          want;
      i2s_pkg::underrun_count_t cnt;
      i2s_pkg::underrun_count_t base;
      int                       silent;
      random_frame(f);
      write_one(f);
      random_frame(f);
      write_one(f);
      skip_silence(got, base, silent);   // Second frame queued, base is settled
      want = exp_q.pop_front();
      check_frame("first frame before underrun", got, want);
      next_capture(got, cnt);
      want = exp_q.pop_front();
      check_frame("second frame before underrun", got, want);
      repeat (SILENT_WAIT) begin
         next_capture(got, cnt);
         check_frame("frame with FIFO drained", got, '0);
      end
      random_frame(f);
      write_one(f);
      random_frame(f);
      write_one(f);
      skip_silence(got, cnt, silent);
      check_count("underrun_count after recovery", cnt,
                  base + i2s_pkg::underrun_count_t'(SILENT_WAIT + silent));
      want = exp_q.pop_front();
      check_frame("first frame after underrun", got, want);
      next_capture(got, cnt);
      want = exp_q.pop_front();
      check_frame("second frame after underrun", got, want);
   endtask

   initial begin
      frame_in = '0;
      write_frame = 1'b0;
      rng_state = 32'h7ac8_0c4a;
      test_reset_state();
      test_single_frame();
      test_stream();
      test_full();
      test_underrun();
      $display("No errors");
      $finish;
   end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic ac_mclk,
   output logic clk_soc,
   output logic reset
);

   initial begin
      ac_mclk = 1'b0;
      forever #4 ac_mclk = ~ac_mclk;   // 8 ns codec master clock
   end

   // System clock, unrelated to ac_mclk
   initial begin
      clk_soc = 1'b0;
      forever #3 clk_soc = ~clk_soc;   // 6 ns
   end

   initial begin
      reset = 1'b1;
      repeat (3) @(posedge ac_mclk);   // 3 ac_mclk cycles, also covers 4 clk_soc edges
      #2;                              // Off the rising edges of both clocks
      reset = 1'b0;
   end

endmodule
